// ==== hdl/data_port.sv ====
////////////////////////////////////////////////////////////
// data port
// holds one core load or store until memory takes it,
// then waits for the load reply and returns the data
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module data_port (
    input  logic                          clock,
    input  logic                          reset,
    mem_req_if.requester                  bus,
    input  mem_bus_pkg::bus_command_t     data_command,
    input  logic [mem_bus_pkg::xlen-1:0]  data_addr,
    input  logic [63:0]                   data_wdata,
    input  mem_bus_pkg::mem_size_t        data_size,
    output logic                          data_busy,
    output logic [63:0]                   load_data,
    output logic                          load_valid
);
    import mem_bus_pkg::*;

    // request still waiting for acceptance, bus_none when empty
    bus_command_t    req_cmd;
    // load accepted, reply outstanding
    logic            load_wait;
    logic [xlen-1:0] req_addr;
    logic [63:0]     req_wdata;
    mem_size_t       req_size;
    logic            take;

    // strobe only counts while idle
    assign take = (data_command != bus_none) && !data_busy;

    assign bus.command = req_cmd;
    assign bus.addr    = req_addr;
    assign bus.wdata   = req_wdata;
    assign bus.size    = req_size;

    ////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            req_cmd    <= bus_none;
            load_wait  <= 1'b0;
            data_busy  <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= 1'b0;
            if (take) begin
                req_cmd   <= data_command;
                data_busy <= 1'b1;
            end else if (req_cmd != bus_none && bus.accepted) begin
                req_cmd <= bus_none;
                // store is done once accepted
                if (req_cmd == bus_store) begin
                    data_busy <= 1'b0;
                end else begin
                    load_wait <= 1'b1;
                end
            end else if (load_wait && bus.reply_valid) begin
                load_wait  <= 1'b0;
                data_busy  <= 1'b0;
                load_valid <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (take) begin
            req_addr  <= data_addr;
            req_wdata <= data_wdata;
            req_size  <= data_size;
        end
        if (load_wait && bus.reply_valid) begin
            // word loads come back in the low half, zero-extended
            load_data <= (req_size == word) ? {32'b0, bus.reply_data.dbl[31:0]}
                                            : bus.reply_data.dbl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
////////////////////////////////////////////////////////////
// instruction fetch unit
// sequential pc, one double-word fetch in flight at a time,
// picks the addressed instruction out of the reply
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter logic [mem_bus_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clock,
    input  logic                          reset,
    mem_req_if.requester                  bus,
    input  logic                          fetch_stall,
    output logic [31:0]                   fetch_inst,
    output logic [mem_bus_pkg::xlen-1:0]  fetch_pc,
    output logic                          fetch_valid
);
    import mem_bus_pkg::*;

    logic [xlen-1:0] pc;
    // fetch accepted, reply not back yet
    logic            waiting;
    // request shown on the link but not accepted
    logic            holding;
    logic            issue;

    // stall blocks new fetches only
    // a request already shown stays up until memory takes it
    assign issue = !waiting && (!fetch_stall || holding);

    assign bus.command = issue ? bus_load : bus_none;
    // double-aligned address of the pc
    assign bus.addr    = {pc[xlen-1:3], 3'b000};
    assign bus.wdata   = '0;
    assign bus.size    = double;

    ////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc          <= reset_pc;
            waiting     <= 1'b0;
            holding     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            holding     <= issue && !bus.accepted;
            fetch_valid <= 1'b0;
            if (issue && bus.accepted) begin
                waiting <= 1'b1;
            end
            if (waiting && bus.reply_valid) begin
                waiting     <= 1'b0;
                fetch_valid <= 1'b1;
                pc          <= pc + xlen'(4);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction and pc output
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (waiting && bus.reply_valid) begin
            // bit 2 selects upper or lower half of the double
            fetch_inst <= pc[2] ? bus.reply_data.inst.hi : bus.reply_data.inst.lo;
            fetch_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
////////////////////////////////////////////////////////////
// memory bus arbiter
// data requests win over fetches, accepted loads are
// recorded by tag so each reply reaches its owner
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                          clock,
    input  logic                          reset,
    mem_req_if.arbiter                    fetch_bus,
    mem_req_if.arbiter                    data_bus,
    input  mem_bus_pkg::mem_tag_t         mem2proc_response,
    input  mem_bus_pkg::mem_tag_t         mem2proc_tag,
    input  logic [63:0]                   mem2proc_data,
    output mem_bus_pkg::bus_command_t     proc2mem_command,
    output logic [mem_bus_pkg::xlen-1:0]  proc2mem_addr,
    output logic [63:0]                   proc2mem_data,
    output mem_bus_pkg::mem_size_t        proc2mem_size
);
    import mem_bus_pkg::*;

    // owner codes for the tag table
    localparam logic [1:0] own_none  = 2'b00;
    localparam logic [1:0] own_data  = 2'b01;
    localparam logic [1:0] own_fetch = 2'b10;

    logic [1:0] owner_q [16];
    logic       data_sel;
    logic       granted;
    logic       load_taken;
    logic [1:0] grant_owner;

    ////////////////////////////////////////////////////////////
    // grant
    ////////////////////////////////////////////////////////////
    assign data_sel = (data_bus.command != bus_none);

    always_comb begin
        if (data_sel) begin
            proc2mem_command = data_bus.command;
            proc2mem_addr    = data_bus.addr;
            proc2mem_data    = data_bus.wdata;
            proc2mem_size    = data_bus.size;
        end else begin
            // fetch side, always a double load
            proc2mem_command = fetch_bus.command;
            proc2mem_addr    = fetch_bus.addr;
            proc2mem_data    = fetch_bus.wdata;
            proc2mem_size    = double;
        end
    end

    // memory took whatever is on the bus this cycle
    assign granted    = (proc2mem_command != bus_none) && (mem2proc_response != '0);
    assign load_taken = granted && (proc2mem_command == bus_load);
    assign grant_owner = data_sel ? own_data : own_fetch;

    assign data_bus.accepted  = granted && data_sel;
    assign fetch_bus.accepted = granted && !data_sel;

    ////////////////////////////////////////////////////////////
    // reply routing
    ////////////////////////////////////////////////////////////
    // tag zero never gets recorded, so no reply matches it
    assign data_bus.reply_valid  = (mem2proc_tag != '0) &&
                                   (owner_q[mem2proc_tag] == own_data);
    assign fetch_bus.reply_valid = (mem2proc_tag != '0) &&
                                   (owner_q[mem2proc_tag] == own_fetch);

    assign data_bus.reply_data  = mem2proc_data;
    assign fetch_bus.reply_data = mem2proc_data;

    ////////////////////////////////////////////////////////////
    // owner table
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                owner_q[i] <= own_none;
            end
        end else begin
            // retire the entry whose reply arrives
            if (mem2proc_tag != '0) begin
                owner_q[mem2proc_tag] <= own_none;
            end
            // new tag from memory, stores get no reply and no entry
            if (load_taken) begin
                owner_q[mem2proc_response] <= grant_owner;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// memory bus definitions
// widths, command and size codes, tags and the 64-bit
// memory word shared by fetch, data port and arbiter
////////////////////////////////////////////////////////////

`default_nettype none

package mem_bus_pkg;

    // address width
    parameter int xlen = 32;

    // bus command codes
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // access size codes, byte and half not supported here
    typedef enum logic [1:0] {
        word   = 2'h2,
        double = 2'h3
    } mem_size_t;

    // transaction tag, zero means no tag
    typedef logic [3:0] mem_tag_t;

    // two instructions packed in one memory word
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } inst_pair_t;

    // one memory word, read as data or as two instructions
    typedef union packed {
        logic [63:0] dbl;
        inst_pair_t  inst;
    } mem_word_t;

endpackage

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
////////////////////////////////////////////////////////////
// memory request channel
// one requester talks to the bus arbiter over this link
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
    import mem_bus_pkg::*;

    // requester side
    bus_command_t    command;
    logic [xlen-1:0] addr;
    logic [63:0]     wdata;
    mem_size_t       size;

    // arbiter side
    logic            accepted;
    logic            reply_valid;
    mem_word_t       reply_data;

    modport requester (
        output command, addr, wdata, size,
        input  accepted, reply_valid, reply_data
    );

    modport arbiter (
        input  command, addr, wdata, size,
        output accepted, reply_valid, reply_data
    );

endinterface

`default_nettype wire

// ==== hdl/proc_mem_top.sv ====
////////////////////////////////////////////////////////////
// processor memory front end
// fetch unit and data port sharing one tagged memory bus
// through the arbiter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module proc_mem_top #(
    parameter logic [mem_bus_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                          clock,
    input  logic                          reset,
    // memory side
    input  mem_bus_pkg::mem_tag_t         mem2proc_response,
    input  mem_bus_pkg::mem_tag_t         mem2proc_tag,
    input  logic [63:0]                   mem2proc_data,
    output mem_bus_pkg::bus_command_t     proc2mem_command,
    output logic [mem_bus_pkg::xlen-1:0]  proc2mem_addr,
    output logic [63:0]                   proc2mem_data,
    output mem_bus_pkg::mem_size_t        proc2mem_size,
    // fetch side
    input  logic                          fetch_stall,
    output logic [31:0]                   fetch_inst,
    output logic [mem_bus_pkg::xlen-1:0]  fetch_pc,
    output logic                          fetch_valid,
    // core data side
    input  mem_bus_pkg::bus_command_t     data_command,
    input  logic [mem_bus_pkg::xlen-1:0]  data_addr,
    input  logic [63:0]                   data_wdata,
    input  mem_bus_pkg::mem_size_t        data_size,
    output logic                          data_busy,
    output logic [63:0]                   load_data,
    output logic                          load_valid
);

    // one channel per requester
    mem_req_if fetch_bus ();
    mem_req_if data_bus ();

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch_unit (
        .clock       (clock),
        .reset       (reset),
        .bus         (fetch_bus.requester),
        .fetch_stall (fetch_stall),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    data_port u_data_port (
        .clock        (clock),
        .reset        (reset),
        .bus          (data_bus.requester),
        .data_command (data_command),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_size    (data_size),
        .data_busy    (data_busy),
        .load_data    (load_data),
        .load_valid   (load_valid)
    );

    // data side has priority on the shared bus
    mem_arbiter u_mem_arbiter (
        .clock             (clock),
        .reset             (reset),
        .fetch_bus         (fetch_bus.arbiter),
        .data_bus          (data_bus.arbiter),
        .mem2proc_response (mem2proc_response),
        .mem2proc_tag      (mem2proc_tag),
        .mem2proc_data     (mem2proc_data),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .proc2mem_size     (proc2mem_size)
    );

endmodule

`default_nettype wire

// ==== proc_mem.f ====
hdl/mem_bus_pkg.sv
hdl/mem_req_if.sv
hdl/fetch_unit.sv
hdl/data_port.sv
hdl/mem_arbiter.sv
hdl/proc_mem_top.sv
verification/tb_clock_gen.sv
verification/mem_model.sv
verification/proc_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the proc_mem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module proc_mem_tb \
    -f proc_mem.f \
    -o proc_mem_sim

./obj_dir/proc_mem_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation ok"

// ==== verification/mem_model.sv ====
////////////////////////////////////////////////////////////
// tagged memory model
// random refusals, load replies 2 to 5 cycles after
// acceptance, word and double accesses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic                       clock,
    input  logic                       reset,
    input  mem_bus_pkg::bus_command_t  proc2mem_command,
    input  logic [31:0]                proc2mem_addr,
    input  logic [63:0]                proc2mem_data,
    input  mem_bus_pkg::mem_size_t     proc2mem_size,
    output mem_bus_pkg::mem_tag_t      mem2proc_response,
    output mem_bus_pkg::mem_tag_t      mem2proc_tag,
    output logic [63:0]                mem2proc_data
);
    import mem_bus_pkg::*;

    // 8 KB of doubles
    logic [63:0] mem [1024];
    logic        pending [16];
    int          due [16];
    logic [63:0] rdata [16];
    int          now;
    logic        refuse;
    mem_tag_t    free_tag;
    mem_tag_t    ready_tag;

    function automatic logic [63:0] fill_word(input logic [31:0] a);
        return {~a, a ^ 32'h3c5a_96e1};
    endfunction

    // word reads return the addressed word in the low half
    function automatic logic [63:0] read_word(input logic [31:0] a, input mem_size_t s);
        logic [63:0] d;
        d = mem[a[12:3]];
        if (s == word && a[2]) begin
            return {d[31:0], d[63:32]};
        end
        return d;
    endfunction

    initial begin
        void'($urandom(32'h8e97_e272));
    end

    // lowest free tag that is not on the reply lines
    always_comb begin
        free_tag  = '0;
        ready_tag = '0;
        for (int t = 15; t >= 1; t--) begin
            if (!pending[t] && mem_tag_t'(t) != mem2proc_tag) begin
                free_tag = mem_tag_t'(t);
            end
            if (pending[t] && due[t] <= now) begin
                ready_tag = mem_tag_t'(t);
            end
        end
    end

    assign mem2proc_response = (proc2mem_command != bus_none && !refuse) ? free_tag : '0;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int t = 0; t < 16; t++) begin
                pending[t] <= 1'b0;
            end
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= fill_word(32'(i) << 3);
            end
            refuse       <= 1'b0;
            now          <= 0;
            mem2proc_tag <= '0;
        end else begin
            refuse       <= ($urandom % 4) == 0;
            now          <= now + 1;
            // one reply per cycle
            mem2proc_tag <= ready_tag;
            if (ready_tag != '0) begin
                pending[ready_tag] <= 1'b0;
                mem2proc_data      <= rdata[ready_tag];
            end
            if (mem2proc_response != '0 && proc2mem_command == bus_load) begin
                pending[mem2proc_response] <= 1'b1;
                due[mem2proc_response]     <= now + 1 + int'($urandom % 4);
                rdata[mem2proc_response]   <= read_word(proc2mem_addr, proc2mem_size);
            end
            if (mem2proc_response != '0 && proc2mem_command == bus_store) begin
                if (proc2mem_size == double) begin
                    mem[proc2mem_addr[12:3]] <= proc2mem_data;
                end else if (proc2mem_addr[2]) begin
                    mem[proc2mem_addr[12:3]][63:32] <= proc2mem_data[31:0];
                end else begin
                    mem[proc2mem_addr[12:3]][31:0] <= proc2mem_data[31:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/proc_mem_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the processor memory front end
// table of data operations against the tagged memory model,
// with fetch stream, bus priority and stall checks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module proc_mem_tb;
    import mem_bus_pkg::*;

    localparam logic [31:0] start_pc    = 32'h0000_0104;
    localparam int          num_ops     = 12;
    localparam int          cycle_limit = num_ops * 40 + 500;

    typedef struct packed {
        bus_command_t cmd;
        logic [31:0]  addr;
        mem_size_t    size;
        logic [63:0]  wdata;
        logic [63:0]  expect_data;
        logic         stall;
    } data_op_t;

    logic         clock;
    logic         reset;
    mem_tag_t     mem2proc_response;
    mem_tag_t     mem2proc_tag;
    logic [63:0]  mem2proc_data;
    bus_command_t proc2mem_command;
    logic [31:0]  proc2mem_addr;
    logic [63:0]  proc2mem_data;
    mem_size_t    proc2mem_size;
    logic         fetch_stall;
    logic [31:0]  fetch_inst;
    logic [31:0]  fetch_pc;
    logic         fetch_valid;
    bus_command_t data_command;
    logic [31:0]  data_addr;
    logic [63:0]  data_wdata;
    mem_size_t    data_size;
    logic         data_busy;
    logic [63:0]  load_data;
    logic         load_valid;

    data_op_t     ops [num_ops];
    logic [63:0]  shadow [1024];
    // error counts
    int           mon_mismatches = 0;
    int           mon_failures   = 0;
    int           drv_mismatches = 0;
    int           drv_failures   = 0;
    int           timeouts       = 0;
    int           cycles         = 0;
    // monitor state
    logic [31:0]  exp_pc         = start_pc;
    int           fetch_count    = 0;
    int           stall_pulses   = 0;
    int           busy_falls     = 0;
    logic         prev_busy      = 1'b0;
    logic         prev_stall     = 1'b0;
    logic         pending        = 1'b0;
    bus_command_t pend_cmd;
    logic [31:0]  pend_addr;
    mem_size_t    pend_size;
    logic [63:0]  pend_wdata;

    tb_clock_gen #(.reset_cycles(16)) u_clock_gen (.clock(clock), .reset(reset));
    mem_model u_mem (.*);
    proc_mem_top #(.reset_pc(start_pc)) u_dut (.*);

    function automatic logic [63:0] fill_word(input logic [31:0] a);
        return {~a, a ^ 32'h3c5a_96e1};
    endfunction

    // expected load value with word loads zero-extended
    function automatic logic [63:0] shadow_load(input logic [31:0] a, input mem_size_t s);
        logic [63:0] d;
        d = shadow[a[12:3]];
        if (s == double) begin
            return d;
        end
        return {32'h0, a[2] ? d[63:32] : d[31:0]};
    endfunction

    task automatic store_shadow(input data_op_t op);
        if (op.size == double) begin
            shadow[op.addr[12:3]] = op.wdata;
        end else if (op.addr[2]) begin
            shadow[op.addr[12:3]][63:32] = op.wdata[31:0];
        end else begin
            shadow[op.addr[12:3]][31:0] = op.wdata[31:0];
        end
    endtask

    ////////////////////////////////////////////////////////////
    // data operations above the code region
    ////////////////////////////////////////////////////////////
    task automatic load_table();
        ops[0]  = '{bus_store, 32'h1000, double, 64'h0123_4567_89ab_cdef, 64'h0, 1'b0};
        ops[1]  = '{bus_load,  32'h1000, double, 64'h0, 64'h0123_4567_89ab_cdef, 1'b1};
        ops[2]  = '{bus_store, 32'h1008, word,   64'hffff_ffff_dead_beef, 64'h0, 1'b1};
        ops[3]  = '{bus_load,  32'h1008, word,   64'h0, 64'h0000_0000_dead_beef, 1'b0};
        ops[4]  = '{bus_store, 32'h100c, word,   64'h1111_1111_cafe_f00d, 64'h0, 1'b0};
        ops[5]  = '{bus_load,  32'h1008, double, 64'h0, 64'hcafe_f00d_dead_beef, 1'b1};
        ops[6]  = '{bus_load,  32'h100c, word,   64'h0, 64'h0000_0000_cafe_f00d, 1'b1};
        ops[7]  = '{bus_store, 32'h1010, double, 64'ha5a5_5a5a_0f0f_f0f0, 64'h0, 1'b0};
        ops[8]  = '{bus_store, 32'h1014, word,   64'h0000_0000_7654_3210, 64'h0, 1'b0};
        ops[9]  = '{bus_load,  32'h1010, double, 64'h0, 64'h7654_3210_0f0f_f0f0, 1'b1};
        // untouched words still hold the fill pattern
        ops[10] = '{bus_load,  32'h1018, word,   64'h0, 64'h0000_0000_3c5a_86f9, 1'b0};
        ops[11] = '{bus_load,  32'h101c, word,   64'h0, 64'h0000_0000_ffff_efe7, 1'b0};
    endtask

    // strobe one entry, then wait for data_busy to drop
    task automatic run_op(input data_op_t op);
        fetch_stall  = op.stall;
        data_command = op.cmd;
        data_addr    = op.addr;
        data_wdata   = op.wdata;
        data_size    = op.size;
        @(posedge clock);
        #1;
        data_command = bus_none;
        assert (data_busy) else begin
            drv_failures++;
            $display("data_busy did not rise after the strobe at %0t", $time);
        end
        while (data_busy) begin
            @(posedge clock);
            #1;
        end
        if (op.cmd == bus_load) begin
            assert (load_valid) else begin
                drv_failures++;
                $display("no load_valid when data_busy fell at %0t", $time);
            end
            assert (load_data == op.expect_data && load_data == shadow_load(op.addr, op.size))
            else begin
                drv_mismatches++;
                $display("Mismatch at %0t: load_data got %h expected %h", $time,
                         load_data, op.expect_data);
            end
        end else begin
            store_shadow(op);
        end
        // idle gap with the stall level unchanged
        repeat (3) begin
            @(posedge clock);
            #1;
        end
        fetch_stall = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures, %0d fetches checked",
                 mon_mismatches + drv_mismatches, mon_failures + drv_failures + timeouts,
                 fetch_count);
        if (mon_mismatches + drv_mismatches + mon_failures + drv_failures + timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // monitor sampling on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clock) begin
        logic [63:0] want;
        if (!reset) begin
            if (fetch_stall && !prev_stall) begin
                stall_pulses = 0;
            end
            if (fetch_valid) begin
                want = shadow_load(exp_pc, word);
                assert (fetch_pc == exp_pc) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: fetch_pc got %h expected %h", $time,
                             fetch_pc, exp_pc);
                end
                assert (fetch_inst == want[31:0]) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: fetch_inst got %h expected %h", $time,
                             fetch_inst, want[31:0]);
                end
                exp_pc = exp_pc + 32'd4;
                fetch_count++;
                if (fetch_stall) begin
                    stall_pulses++;
                end
                assert (stall_pulses <= 1) else begin
                    mon_failures++;
                    $display("second fetch delivered during a stall at %0t", $time);
                end
            end
            // waiting data request owns the bus
            if (pending) begin
                assert (proc2mem_command == pend_cmd) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: proc2mem_command got %0d expected %0d", $time,
                             proc2mem_command, pend_cmd);
                end
                assert (proc2mem_addr == pend_addr) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: proc2mem_addr got %h expected %h", $time,
                             proc2mem_addr, pend_addr);
                end
                assert (proc2mem_size == pend_size) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: proc2mem_size got %0d expected %0d", $time,
                             proc2mem_size, pend_size);
                end
                if (pend_cmd == bus_store) begin
                    assert (proc2mem_data == pend_wdata) else begin
                        mon_mismatches++;
                        $display("Mismatch at %0t: proc2mem_data got %h expected %h", $time,
                                 proc2mem_data, pend_wdata);
                    end
                end
                if (mem2proc_response != '0) begin
                    pending = 1'b0;
                end
            end else if (proc2mem_command != bus_none) begin
                // fetches go out as double loads
                assert (proc2mem_size == double) else begin
                    mon_mismatches++;
                    $display("Mismatch at %0t: proc2mem_size got %0d expected %0d", $time,
                             proc2mem_size, double);
                end
            end
            if (data_command != bus_none && !data_busy) begin
                pending    = 1'b1;
                pend_cmd   = data_command;
                pend_addr  = data_addr;
                pend_size  = data_size;
                pend_wdata = data_wdata;
            end
            if (prev_busy && !data_busy) begin
                busy_falls++;
            end
            prev_busy  = data_busy;
            prev_stall = fetch_stall;
        end
    end

    // run limit from the table length
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            timeouts++;
            $display("run did not finish within %0d cycles", cycle_limit);
            finish_run();
        end
    end

    initial begin
        fetch_stall  = 1'b0;
        data_command = bus_none;
        data_addr    = '0;
        data_wdata   = '0;
        data_size    = double;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = fill_word(32'(i) << 3);
        end
        load_table();
        @(negedge reset);
        @(posedge clock);
        #1;
        for (int i = 0; i < num_ops; i++) begin
            run_op(ops[i]);
        end
        assert (busy_falls == num_ops) else begin
            drv_failures++;
            $display("data_busy fell %0d times for %0d operations", busy_falls, num_ops);
        end
        assert (fetch_count > 8) else begin
            drv_failures++;
            $display("fetch stream delivered only %0d instructions", fetch_count);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset
// 40 ns clock, reset held for a fixed number of cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // release just after a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire
